/* logic/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path and address width
`define XLEN 32

`define REG_ADDR_W 5 // register number width

// data memory depth, counted in 32-bit words
`define DMEM_WORDS 256

`endif

/* logic/exePkg.sv */
package exePkg;

	// integer ALU functions
	typedef enum logic [3:0]
	{
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd
	} aluOp;

	// same codes as funct3 of the branch instructions
	typedef enum logic [2:0]
	{
		brEq = 3'b000,
		brNe = 3'b001,
		brLt = 3'b100,
		brGe = 3'b101,
		brLtu = 3'b110,
		brGeu = 3'b111
	} brCond;

	typedef enum logic [1:0] {mul, mulh, mulhsu, mulhu} mulOp;

	typedef enum logic [2:0] {selAlu, selLink, selMul, selLui, selMem, selAuipc} wbSel; // wb source

endpackage

/* logic/memPkg.sv */
package memPkg;

	// data memory access kinds
	typedef enum logic [3:0]
	{
		memNone,
		lb,
		lh,
		lw,
		lbu, // zero extended loads
		lhu,
		sb,
		sh,
		sw
	} memOp;

endpackage

/* logic/alu.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module alu import exePkg::*;
(
	input aluOp fn,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result
);

	logic [4:0] shamt;

	assign shamt = b[4:0]; // only low five bits count for RV32

	always_comb
	begin
		if (!$isunknown(fn))
		begin
			assert (fn inside {aluAdd, aluSub, aluSll, aluSlt, aluSltu,
				aluXor, aluSrl, aluSra, aluOr, aluAnd})
			else
				$error("alu: unknown function code %0d", fn);
		end
		case (fn)
			aluAdd:
				result = a + b;
			aluSub:
				result = a - b;
			aluSll:
				result = a << shamt;
			aluSlt:
				result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			aluSltu:
				result = {{(`XLEN-1){1'b0}}, a < b};
			aluXor:
				result = a ^ b;
			aluSrl:
				result = a >> shamt;
			aluSra:
				result = $signed(a) >>> shamt; // keeps sign bit
			aluOr:
				result = a | b;
			aluAnd:
				result = a & b;
			default:
				result = '0;
		endcase
	end

endmodule

/* logic/branchUnit.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module branchUnit import exePkg::*;
(
	input logic clk,
	input logic nrst,
	input logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input brCond cond,
	input logic isBranch,
	input logic jal,
	input logic jalr,
	output logic [`XLEN-1:0] target,
	output logic taken
);

	logic condTrue;
	logic [`XLEN-1:0] jalrSum;
	logic [`XLEN-1:0] targetNext;

	always_comb
	begin
		case (cond)
			brEq: condTrue = (opA == opB);
			brNe: condTrue = (opA != opB);
			brLt: condTrue = ($signed(opA) < $signed(opB));
			brGe: condTrue = ($signed(opA) >= $signed(opB));
			brLtu: condTrue = (opA < opB);
			brGeu: condTrue = (opA >= opB);
			default: condTrue = 1'b0; // funct3 2 and 3 are not branches
		endcase
	end

	assign jalrSum = opA + opB;
	assign targetNext = jalr ? {jalrSum[`XLEN-1:1], 1'b0}
		: jal ? pc + jImm
		: pc + bImm;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			target <= '0;
			taken <= 1'b0;
		end
		else
		begin
			target <= targetNext;
			taken <= jal | jalr | (isBranch & condTrue);
		end
	end

	// issue stage decodes one jump kind at a time
	assert property (@(posedge clk) disable iff (!nrst) !(jal && jalr))
		else $error("branchUnit: jal and jalr both set");

endmodule

/* logic/mulUnit.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module mulUnit import exePkg::*;
(
	input mulOp fn,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result
);

	logic aSigned;
	logic bSigned;
	logic signed [`XLEN:0] aExt; // one extra bit for the sign
	logic signed [`XLEN:0] bExt;
	logic signed [2*`XLEN+1:0] product;

	// mulhsu takes a signed, b unsigned
	assign aSigned = (fn == mulh) || (fn == mulhsu);
	assign bSigned = (fn == mulh);

	assign aExt = {aSigned & a[`XLEN-1], a};
	assign bExt = {bSigned & b[`XLEN-1], b};

	assign product = aExt * bExt;

	// low word is the same for every signedness
	assign result = (fn == mul) ? product[`XLEN-1:0] : product[2*`XLEN-1:`XLEN];

endmodule

/* logic/dataMem.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module dataMem import memPkg::*;
(
	input logic clk,
	input logic nrst,
	input memOp fn,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input logic [`XLEN-1:0] sImm,
	output logic [`XLEN-1:0] loadData,
	output logic misaligned
);

	localparam int IDX_W = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] mem [`DMEM_WORDS];

	memOp fn5;
	logic [`XLEN-1:0] addr5;
	logic [`XLEN-1:0] storeData5;

	logic isStore4;
	logic isLoad5;
	logic isStore5;
	logic mis5;
	logic [IDX_W-1:0] wordIdx;
	logic [1:0] byteOff;
	logic [3:0] wmask;
	logic [`XLEN-1:0] wdata;
	logic [`XLEN-1:0] rdWord;
	logic [7:0] rdByte;
	logic [15:0] rdHalf;
	logic [`XLEN-1:0] ext;

	assign isStore4 = fn inside {sb, sh, sw};

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			fn5 <= memNone;
		else
			fn5 <= fn;
	end

	// stores are base + sImm, loads base + I-immediate on opB
	always_ff @(posedge clk)
	begin
		addr5 <= isStore4 ? opA + sImm : opA + opB;
		storeData5 <= opB;
	end

	assign isLoad5 = fn5 inside {lb, lh, lw, lbu, lhu};
	assign isStore5 = fn5 inside {sb, sh, sw};
	assign wordIdx = addr5[IDX_W+1:2]; // wraps modulo memory size
	assign byteOff = addr5[1:0];

	assign mis5 = ((fn5 inside {lh, lhu, sh}) && addr5[0])
		|| ((fn5 inside {lw, sw}) && (addr5[1:0] != 2'b00));

	always_comb
	begin
		case (fn5)
			sb:
			begin
				wmask = 4'b0001 << byteOff;
				wdata = {4{storeData5[7:0]}};
			end
			sh:
			begin
				wmask = 4'b0011 << byteOff;
				wdata = {2{storeData5[15:0]}};
			end
			default:
			begin
				wmask = 4'b1111;
				wdata = storeData5;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (isStore5 && !mis5)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (wmask[i])
					mem[wordIdx][8*i +: 8] <= wdata[8*i +: 8]; // little endian lanes
			end
		end
	end

	assign rdWord = mem[wordIdx];
	assign rdByte = rdWord[8*byteOff +: 8];
	assign rdHalf = rdWord[16*byteOff[1] +: 16];

	always_comb
	begin
		case (fn5)
			lb: ext = {{(`XLEN-8){rdByte[7]}}, rdByte};
			lbu: ext = {{(`XLEN-8){1'b0}}, rdByte};
			lh: ext = {{(`XLEN-16){rdHalf[15]}}, rdHalf};
			lhu: ext = {{(`XLEN-16){1'b0}}, rdHalf};
			default: ext = rdWord;
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			loadData <= '0;
			misaligned <= 1'b0;
		end
		else
		begin
			loadData <= (isLoad5 && !mis5) ? ext : '0; // suppressed access reads zero
			misaligned <= mis5;
		end
	end

	// flag belongs to the access two edges later
	assert property (@(posedge clk) disable iff (!nrst) (fn == memNone) |=> ##1 !misaligned)
		else $error("dataMem: misaligned raised for a non-memory op");

endmodule

/* logic/exeStage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module exeStage import exePkg::*, memPkg::*;
(
	input logic clk,
	input logic nrst,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input logic [`XLEN-1:0] uImm,
	input logic [`XLEN-1:0] sImm,
	input logic [`XLEN-1:0] pc,
	input logic [`REG_ADDR_W-1:0] rd,
	input logic we,
	input logic isBranch,
	input logic jal,
	input logic jalr,
	input aluOp aluFn,
	input mulOp mulFn,
	input brCond cond,
	input wbSel resultSel,
	input memOp memFn,
	output logic [`XLEN-1:0] wbData,
	output logic [`REG_ADDR_W-1:0] rdOut,
	output logic weOut,
	output logic bjTaken,
	output logic addrMisaligned,
	output logic [`XLEN-1:0] target
);

	// pipe 5
	logic [`XLEN-1:0] opA5;
	logic [`XLEN-1:0] opB5;
	logic [`XLEN-1:0] pc5;
	logic [`XLEN-1:0] uImm5;
	logic [`REG_ADDR_W-1:0] rd5;
	logic we5;
	aluOp aluFn5;
	mulOp mulFn5;
	wbSel resultSel5;

	logic [`XLEN-1:0] aluRes5;
	logic [`XLEN-1:0] mulRes5;
	logic [`XLEN-1:0] memData6; // already registered inside dataMem

	// pipe 6
	logic [`XLEN-1:0] aluRes6;
	logic [`XLEN-1:0] mulRes6;
	logic [`XLEN-1:0] uImm6;
	logic [`XLEN-1:0] auipc6;
	logic [`XLEN-1:0] link6;
	logic [`REG_ADDR_W-1:0] rd6;
	logic we6;
	wbSel resultSel6;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			opA5 <= '0;
			opB5 <= '0;
			pc5 <= '0;
			uImm5 <= '0;
			rd5 <= '0;
			we5 <= 1'b0;
			aluFn5 <= aluAdd;
			mulFn5 <= mul;
			resultSel5 <= selAlu;
		end
		else
		begin
			opA5 <= opA;
			opB5 <= opB;
			pc5 <= pc;
			uImm5 <= uImm;
			rd5 <= rd;
			we5 <= we;
			aluFn5 <= aluFn;
			mulFn5 <= mulFn;
			resultSel5 <= resultSel;
		end
	end

	alu alu_i
	(
		.fn(aluFn5),
		.a(opA5),
		.b(opB5),
		.result(aluRes5)
	);

	mulUnit mulUnit_i
	(
		.fn(mulFn5),
		.a(opA5),
		.b(opB5),
		.result(mulRes5)
	);

	// control flow resolves off the stage-4 inputs
	branchUnit branchUnit_i
	(
		.clk(clk),
		.nrst(nrst),
		.pc(pc),
		.opA(opA),
		.opB(opB),
		.bImm(bImm),
		.jImm(jImm),
		.cond(cond),
		.isBranch(isBranch),
		.jal(jal),
		.jalr(jalr),
		.target(target),
		.taken(bjTaken)
	);

	dataMem dataMem_i
	(
		.clk(clk),
		.nrst(nrst),
		.fn(memFn),
		.opA(opA),
		.opB(opB),
		.sImm(sImm),
		.loadData(memData6),
		.misaligned(addrMisaligned)
	);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			aluRes6 <= '0;
			mulRes6 <= '0;
			uImm6 <= '0;
			auipc6 <= '0;
			link6 <= '0;
			rd6 <= '0;
			we6 <= 1'b0;
			resultSel6 <= selAlu;
		end
		else
		begin
			aluRes6 <= aluRes5;
			mulRes6 <= mulRes5;
			uImm6 <= uImm5;
			auipc6 <= uImm5 + pc5;
			link6 <= pc5 + `XLEN'd4; // byte addressed return address
			rd6 <= rd5;
			we6 <= we5;
			resultSel6 <= resultSel5;
		end
	end

	always_comb
	begin
		case (resultSel6)
			selAlu: wbData = aluRes6;
			selLink: wbData = link6;
			selMul: wbData = mulRes6;
			selLui: wbData = uImm6;
			selMem: wbData = memData6;
			selAuipc: wbData = auipc6;
			default: wbData = '0;
		endcase
	end

	assign rdOut = rd6;
	assign weOut = we6;

	assert property (@(posedge clk) !nrst |-> !weOut)
		else $error("exeStage: register write enabled during reset");

endmodule

/* testbench/exeChecker.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module exeChecker import exePkg::*, memPkg::*;
(
	input logic clk,
	input logic nrst,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input logic [`XLEN-1:0] uImm,
	input logic [`XLEN-1:0] sImm,
	input logic [`XLEN-1:0] pc,
	input logic [`REG_ADDR_W-1:0] rd,
	input logic we,
	input logic isBranch,
	input logic jal,
	input logic jalr,
	input aluOp aluFn,
	input mulOp mulFn,
	input brCond cond,
	input wbSel resultSel,
	input memOp memFn,
	input logic [`XLEN-1:0] wbData,
	input logic [`REG_ADDR_W-1:0] rdOut,
	input logic weOut,
	input logic bjTaken,
	input logic addrMisaligned,
	input logic [`XLEN-1:0] target,
	input logic testDone,
	input int testIdx,
	output int errors,
	output int checks
);

	localparam int BYTE_W = $clog2(4 * `DMEM_WORDS);

	logic [7:0] memModel [4 * `DMEM_WORDS]; // byte addressed reference memory

	// index 0 is the newest instruction, index 1 the one due on the outputs
	logic [31:0] expData [2];
	logic [4:0] expRd [2];
	logic expWe [2];
	logic expMis [2];
	logic expReset [2]; // entry still holds reset state
	logic [31:0] expTarget;
	logic expTaken;

	int errCount = 0;
	int checkCount = 0;
	int lastChecks = 0;
	int lastErrors = 0;

	assign errors = errCount;
	assign checks = checkCount;

	function automatic logic [31:0] aluModel(aluOp fn, logic [31:0] a, logic [31:0] b);
		case (fn)
			aluAdd: return a + b;
			aluSub: return a - b;
			aluSll: return a << b[4:0];
			aluSlt: return {31'b0, $signed(a) < $signed(b)};
			aluSltu: return {31'b0, a < b};
			aluXor: return a ^ b;
			aluSrl: return a >> b[4:0];
			aluSra: return $signed(a) >>> b[4:0];
			aluOr: return a | b;
			aluAnd: return a & b;
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] mulModel(mulOp fn, logic [31:0] a, logic [31:0] b);
		logic [63:0] p;
		case (fn)
			mul, mulh: p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
			mulhsu: p = {{32{a[31]}}, a} * {32'h0, b};
			default: p = {32'h0, a} * {32'h0, b};
		endcase
		return (fn == mul) ? p[31:0] : p[63:32];
	endfunction

	function automatic logic condHolds(brCond c, logic [31:0] a, logic [31:0] b);
		case (c)
			brEq: return a == b;
			brNe: return a != b;
			brLt: return $signed(a) < $signed(b);
			brGe: return $signed(a) >= $signed(b);
			brLtu: return a < b;
			brGeu: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic string testName(int idx);
		case (idx)
			0: return "reset";
			1: return "memory fill";
			2: return "alu and multiply";
			3: return "lui auipc link";
			4: return "branch and jump";
			5: return "load and store";
			default: return "mixed";
		endcase
	endfunction

	task automatic compareValue(string what, logic [31:0] got, logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("[ERROR] time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// runs one issued instruction through the reference rules
	task automatic modelInput();
		logic [31:0] addr;
		logic [31:0] word;
		logic [15:0] half;
		logic [31:0] ld;
		logic [BYTE_W-1:0] idx;
		logic mis;
		addr = (memFn inside {sb, sh, sw}) ? opA + sImm : opA + opB;
		idx = addr[BYTE_W-1:0]; // wraps around the memory
		mis = ((memFn inside {lh, lhu, sh}) && addr[0])
			|| ((memFn inside {lw, sw}) && addr[1:0] != 2'b00);
		for (int i = 0; i < 4; i++)
			word[8*i +: 8] = memModel[{idx[BYTE_W-1:2], 2'(i)}];
		half = {memModel[{idx[BYTE_W-1:1], 1'b1}], memModel[{idx[BYTE_W-1:1], 1'b0}]};
		ld = '0;
		if (!mis)
		begin
			case (memFn)
				lb: ld = 32'($signed(memModel[idx]));
				lbu: ld = 32'(memModel[idx]);
				lh: ld = 32'($signed(half));
				lhu: ld = 32'(half);
				lw: ld = word;
				sb: memModel[idx] = opB[7:0];
				sh:
				begin
					memModel[{idx[BYTE_W-1:1], 1'b0}] = opB[7:0];
					memModel[{idx[BYTE_W-1:1], 1'b1}] = opB[15:8];
				end
				sw:
				begin
					for (int i = 0; i < 4; i++)
						memModel[{idx[BYTE_W-1:2], 2'(i)}] = opB[8*i +: 8];
				end
				default: ;
			endcase
		end
		case (resultSel)
			selAlu: expData[0] = aluModel(aluFn, opA, opB);
			selLink: expData[0] = pc + 32'd4;
			selMul: expData[0] = mulModel(mulFn, opA, opB);
			selLui: expData[0] = uImm;
			selMem: expData[0] = ld; // zero for non-loads and misaligned loads
			selAuipc: expData[0] = uImm + pc;
			default: expData[0] = '0;
		endcase
		expRd[0] = rd;
		expWe[0] = we;
		expMis[0] = mis;
		expReset[0] = 1'b0;
		expTaken = jal || jalr || (isBranch && condHolds(cond, opA, opB));
		if (jalr)
			expTarget = (opA + opB) & ~32'h1;
		else if (jal)
			expTarget = pc + jImm;
		else
			expTarget = pc + bImm;
	endtask

	always @(posedge clk)
	begin
		if (!nrst)
		begin
			compareValue("weOut during reset", 32'(weOut), 32'h0);
			compareValue("bjTaken during reset", 32'(bjTaken), 32'h0);
			compareValue("addrMisaligned during reset", 32'(addrMisaligned), 32'h0);
			compareValue("wbData during reset", wbData, 32'h0);
			for (int i = 0; i < 2; i++)
			begin
				expData[i] = '0;
				expRd[i] = '0;
				expWe[i] = 1'b0;
				expMis[i] = 1'b0;
				expReset[i] = 1'b1;
			end
			expTarget = '0;
			expTaken = 1'b0;
		end
		else
		begin
			compareValue("weOut", 32'(weOut), 32'(expWe[1]));
			compareValue("addrMisaligned", 32'(addrMisaligned), 32'(expMis[1]));
			if (expWe[1] || expReset[1])
				compareValue("wbData", wbData, expData[1]);
			if (expWe[1])
				compareValue("rdOut", 32'(rdOut), 32'(expRd[1]));
			compareValue("bjTaken", 32'(bjTaken), 32'(expTaken)); // one cycle after issue
			compareValue("target", target, expTarget);
			expData[1] = expData[0];
			expRd[1] = expRd[0];
			expWe[1] = expWe[0];
			expMis[1] = expMis[0];
			expReset[1] = expReset[0];
			modelInput();
		end
		if (testDone)
		begin
			$display("test %0d %s: %0d checks, %0d errors", testIdx, testName(testIdx),
				checkCount - lastChecks, errCount - lastErrors);
			lastChecks = checkCount;
			lastErrors = errCount;
		end
	end

endmodule

/* testbench/exeStageTb.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module exeStageTb import exePkg::*, memPkg::*;
();

	localparam int TEST_LEN = 200;
	localparam int RANDOM_TESTS = 5;
	localparam int TEST_COUNT = RANDOM_TESTS + 2; // reset and memory fill come first
	localparam int DRAIN_CYCLES = 4;
	localparam int RESET_CYCLES = 2;
	localparam int CYCLE_LIMIT = RESET_CYCLES + `DMEM_WORDS + RANDOM_TESTS * TEST_LEN
		+ TEST_COUNT * DRAIN_CYCLES + 50;

	logic clk = 1'b0;
	logic nrst;
	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] bImm;
	logic [`XLEN-1:0] jImm;
	logic [`XLEN-1:0] uImm;
	logic [`XLEN-1:0] sImm;
	logic [`XLEN-1:0] pc;
	logic [`REG_ADDR_W-1:0] rd;
	logic we;
	logic isBranch;
	logic jal;
	logic jalr;
	aluOp aluFn;
	mulOp mulFn;
	brCond cond;
	wbSel resultSel;
	memOp memFn;
	logic [`XLEN-1:0] wbData;
	logic [`REG_ADDR_W-1:0] rdOut;
	logic weOut;
	logic bjTaken;
	logic addrMisaligned;
	logic [`XLEN-1:0] target;
	logic testDone;
	int testIdx;
	int errors;
	int checks;

	logic [31:0] rngState;
	logic [31:0] lastStore; // address of the most recent store
	int cycleCount = 0;

	exeStage exeStage_i (.*);

	exeChecker checker_i (.*);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	// xorshift32
	function logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	task clearInputs();
		opA = '0;
		opB = '0;
		bImm = '0;
		jImm = '0;
		uImm = '0;
		sImm = '0;
		pc = '0;
		rd = '0;
		we = 1'b0;
		isBranch = 1'b0;
		jal = 1'b0;
		jalr = 1'b0;
		aluFn = aluAdd;
		mulFn = mul;
		cond = brEq;
		resultSel = selAlu;
		memFn = memNone;
	endtask

	task fillWord(input int idx);
		logic [31:0] addr;
		addr = 32'(idx) << 2;
		@(posedge clk);
		#1;
		clearInputs();
		memFn = sw;
		opA = addr;
		opB = (addr * 32'h9E37_79B1) ^ {addr[15:0], ~addr[31:16]};
	endtask

	task memAccess();
		logic [31:0] r;
		logic [31:0] addr;
		logic [31:0] off;
		logic [1:0] size;
		r = nextRandom();
		addr = nextRandom() % (4 * `DMEM_WORDS);
		if (r[3:2] == 2'b00)
			addr = {lastStore[31:2], addr[1:0]}; // hit the word just stored
		size = (r[1:0] == 2'b11) ? 2'd2 : r[1:0];
		if (r[6:4] != 3'b000)
		begin
			if (size == 2'd1)
				addr[0] = 1'b0;
			if (size == 2'd2)
				addr[1:0] = 2'b00;
		end
		off = nextRandom();
		off = {{20{off[11]}}, off[11:0]};
		opA = addr - off;
		if (r[7])
		begin
			sImm = off;
			we = 1'b0;
			lastStore = addr;
			case (size)
				2'd0: memFn = sb;
				2'd1: memFn = sh;
				default: memFn = sw;
			endcase
		end
		else
		begin
			opB = off;
			resultSel = selMem;
			case (size)
				2'd0: memFn = r[8] ? lbu : lb;
				2'd1: memFn = r[8] ? lhu : lh;
				default: memFn = lw;
			endcase
		end
	endtask

	// kind 0 alu/mul, 1 upper/link, 2 branch, 3 memory, 4 any of these
	task issue(input int kind);
		logic [31:0] r;
		int k;
		@(posedge clk);
		#1;
		r = nextRandom();
		opA = nextRandom();
		opB = nextRandom();
		bImm = nextRandom();
		jImm = nextRandom();
		sImm = nextRandom();
		pc = nextRandom() & 32'hFFFF_FFFC;
		uImm = {r[31:12], 12'h000};
		rd = r[4:0];
		we = 1'b1;
		isBranch = 1'b0;
		jal = 1'b0;
		jalr = 1'b0;
		memFn = memNone;
		aluFn = aluOp'(4'(nextRandom() % 10));
		mulFn = mulOp'(r[6:5]);
		cond = brCond'({r[9] | r[8], r[8:7]}); // only the six valid codes
		resultSel = selAlu;
		k = (kind == 4) ? int'(r[11:10]) : kind;
		if (r[15:13] == 3'b000)
			k = 5; // bubble
		case (k)
			0: resultSel = r[16] ? selMul : selAlu;
			1: resultSel = r[17] ? selLui : (r[16] ? selAuipc : selLink);
			2:
			begin
				resultSel = selLink;
				case (r[19:18])
					2'd0: isBranch = 1'b1;
					2'd1: jal = 1'b1;
					2'd2: jalr = 1'b1;
					default:
					begin
						isBranch = 1'b1;
						opB = r[20] ? opA : opA ^ 32'h8000_0000;
					end
				endcase
				if (isBranch)
					we = 1'b0;
			end
			3: memAccess();
			default: we = 1'b0;
		endcase
	endtask

	task finishTest(input int idx);
		repeat (DRAIN_CYCLES - 1)
		begin
			@(posedge clk);
			#1;
			clearInputs();
		end
		testIdx = idx;
		testDone = 1'b1;
		@(posedge clk);
		#1;
		testDone = 1'b0;
	endtask

	initial
	begin
		rngState = 32'd60;
		lastStore = '0;
		testDone = 1'b0;
		testIdx = 0;
		clearInputs();
		// live jump and misaligned load held while in reset
		we = 1'b1;
		rd = 5'd7;
		jal = 1'b1;
		pc = 32'h0000_1000;
		resultSel = selLink;
		memFn = lw;
		opA = 32'h0000_0001;
		nrst = 1'b1;
		#1 nrst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 nrst = 1'b1;
		clearInputs();
		finishTest(0);
		for (int i = 0; i < `DMEM_WORDS; i++)
			fillWord(i);
		finishTest(1);
		for (int t = 0; t < RANDOM_TESTS; t++)
		begin
			repeat (TEST_LEN) issue(t);
			finishTest(t + 2);
		end
		$display("all tests: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+logic
logic/exePkg.sv
logic/memPkg.sv
logic/alu.sv
logic/branchUnit.sv
logic/mulUnit.sv
logic/dataMem.sv
logic/exeStage.sv
testbench/exeChecker.sv
testbench/exeStageTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f sim.f --top-module exeStageTb -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
